//--- hdl/jpeg_tail_pkg.sv
/* jpeg entropy coder tail
   shared widths and vector types for the amplitude, packing and stuffing stages */
`default_nettype none

package jpeg_tail_pkg;

    // limits fixed by baseline jpeg
    localparam int MAX_CODE_LEN  = 16;
    localparam int MAX_AMP_SIZE  = 11;
    localparam int MAX_SYM_BITS  = MAX_CODE_LEN + MAX_AMP_SIZE;   // code plus amplitude bits
    localparam int MAX_PAIR_BITS = 2 * MAX_SYM_BITS;              // two symbols per merged word

    localparam logic [7:0] STUFF_BYTE = 8'hff;   // scan bytes equal to this get a zero after them

    // huffman symbol from the table lookup
    typedef logic [15:0]        code_t;       // right-aligned code word
    typedef logic [4:0]         code_len_t;   // 1 to 16
    typedef logic signed [11:0] amp_t;        // coefficient amplitude
    typedef logic [3:0]         amp_size_t;   // size category 0 to 11

    // merged symbol pair, left-aligned
    typedef logic [63:0]        word64_t;
    typedef logic [6:0]         nbits64_t;    // 0 to 64

    // packed scan words
    typedef logic [31:0]        word32_t;
    typedef logic [2:0]         nbytes_t;     // 1 to 4
    typedef logic [7:0]         byte_t;

endpackage

`default_nettype wire

//--- hdl/amp_merge.sv
/* amplitude stage
   size category and ones' complement bits of each amplitude, appended to the code
   and merged pairwise into left-aligned 64-bit words */
`timescale 1ns/10ps
`default_nettype none

module amp_merge
    import jpeg_tail_pkg::*;
(
    input  logic      clk,
    input  logic      resetn,

    input  code_t     sym_code,
    input  code_len_t sym_code_len,
    input  amp_t      sym_amp,
    input  logic      sym_tlast,
    input  logic      sym_valid,
    output logic      sym_hold,

    output word64_t   pair_data,
    output nbits64_t  pair_nbits,
    output logic      pair_tlast,
    output logic      pair_valid,
    input  logic      pair_hold
);

    amp_t                    neg_amp;
    amp_t                    amp_adj;
    logic [MAX_AMP_SIZE-1:0] mag;
    logic [MAX_AMP_SIZE-1:0] amp_mask;
    logic [MAX_AMP_SIZE-1:0] amp_bits;
    amp_size_t               amp_size;
    code_t                   code_mask;
    logic [MAX_SYM_BITS-1:0] sym_bits;
    nbits64_t                sym_nbits;
    word64_t                 sym_word;
    word64_t                 pend_word;
    nbits64_t                pend_nbits;
    logic                    pend_valid;
    word64_t                 held_word;
    nbits64_t                held_nbits;
    logic                    sym_take;
    logic                    emit;

    // magnitude, amplitudes stay within +-2047
    assign neg_amp = -sym_amp;
    assign mag     = sym_amp[11] ? neg_amp[MAX_AMP_SIZE-1:0] : sym_amp[MAX_AMP_SIZE-1:0];

    // size category is the position of the highest set magnitude bit
    always_comb begin
        amp_size = '0;
        for (int i = 0; i < MAX_AMP_SIZE; i++) begin
            if (mag[i]) begin
                amp_size = amp_size_t'(i + 1);
            end
        end
    end

    // negative values send the low bits of amp - 1
    assign amp_adj   = sym_amp[11] ? sym_amp - 12'sd1 : sym_amp;
    assign amp_mask  = {MAX_AMP_SIZE{1'b1}} >> (MAX_AMP_SIZE - amp_size);
    assign amp_bits  = amp_adj[MAX_AMP_SIZE-1:0] & amp_mask;
    assign code_mask = {MAX_CODE_LEN{1'b1}} >> (MAX_CODE_LEN - sym_code_len);

    // code first, amplitude bits right behind it
    assign sym_bits  = ({{MAX_AMP_SIZE{1'b0}}, sym_code & code_mask} << amp_size)
                     | {{MAX_CODE_LEN{1'b0}}, amp_bits};
    assign sym_nbits = nbits64_t'(sym_code_len) + nbits64_t'(amp_size);
    assign sym_word  = word64_t'(sym_bits) << (7'd64 - sym_nbits);   // left-align

    assign held_word  = pend_valid ? pend_word : '0;
    assign held_nbits = pend_valid ? pend_nbits : '0;

    assign sym_hold = pair_valid & pair_hold;   // single output slot
    assign sym_take = sym_valid & ~sym_hold;
    assign emit     = sym_take & (pend_valid | sym_tlast);   // second of a pair or a flush

    always_ff @(posedge clk) begin
        if (!resetn) begin
            pend_valid <= 1'b0;
            pair_valid <= 1'b0;
            pair_tlast <= 1'b0;
        end else begin
            if (pair_valid & ~pair_hold) begin
                pair_valid <= 1'b0;
                pair_tlast <= 1'b0;
            end
            if (emit) begin
                pair_valid <= 1'b1;
                pair_tlast <= sym_tlast;
                pend_valid <= 1'b0;
            end else if (sym_take) begin
                pend_valid <= 1'b1;   // wait for the partner
            end
        end
    end

    always_ff @(posedge clk) begin
        if (emit) begin
            pair_data  <= held_word | (sym_word >> held_nbits);
            pair_nbits <= held_nbits + sym_nbits;
        end
        if (sym_take & ~emit) begin
            pend_word  <= sym_word;
            pend_nbits <= sym_nbits;
        end
    end

    // a zero-length code would vanish from the scan
    a_code_len: assert property (@(posedge clk) disable iff (!resetn)
        sym_valid |-> (sym_code_len != '0) && (sym_code_len <= MAX_CODE_LEN));

    a_pair_bits: assert property (@(posedge clk) disable iff (!resetn)
        pair_valid |-> pair_nbits <= nbits64_t'(MAX_PAIR_BITS));

endmodule

`default_nettype wire

//--- hdl/bit_pack.sv
/* bit packer
   splits long merged words and packs variable-length fields into 32-bit words,
   padding the last partial byte of a segment with ones */
`timescale 1ns/10ps
`default_nettype none

module bit_pack
    import jpeg_tail_pkg::*;
(
    // merged code and amplitude bits
    input  word64_t  in_data,
    input  nbits64_t in_nbits,
    input  logic     in_tlast,
    input  logic     in_valid,
    output logic     in_hold,

    output word32_t  out_data,
    output nbytes_t  out_nbytes,
    output logic     out_tlast,
    output logic     out_valid,
    input  logic     out_hold,

    input  logic     clk,
    input  logic     resetn
);

    word32_t    in32_data;
    logic [5:0] in32_nbits;   // 0 to 32
    logic       in32_tlast;
    logic       in32_valid;
    logic       in32_hold;
    logic       in32_ready;
    logic       in32_take;
    logic       long_in;      // second half of a split word is next
    logic       in_long;

    nbits64_t   bit_count;
    nbits64_t   next_bit_count;
    nbits64_t   count_decr;
    nbits64_t   count_incr;
    nbits64_t   remain;
    nbits64_t   rounded;
    word64_t    bit_packer;
    word64_t    next_bit_packer;
    word64_t    shifted;
    word64_t    load;
    logic       tlast_cycle;  // a segment end is stored
    logic       next_tlast_cycle;
    logic       emit;

    // align to 32 bits, words over 32 bits are rare and take two cycles
    assign in_long    = in_valid & ~long_in & (in_nbits > 7'd32);
    assign in32_ready = ~(in32_valid & in32_hold);
    assign in_hold    = ~in32_ready | in_long;   // sender stalls on the first half

    always_ff @(posedge clk) begin
        if (!resetn) begin
            in32_valid <= 1'b0;
            long_in    <= 1'b0;
        end else if (in32_ready) begin
            in32_valid <= in_valid;
            long_in    <= in_long;
        end
    end

    always_ff @(posedge clk) begin
        if (in32_ready) begin
            if (long_in) begin
                // remainder sits left-aligned in the low half
                in32_data  <= in_data[31:0];
                in32_nbits <= 6'(in_nbits - 7'd32);
                in32_tlast <= in_tlast;
            end else begin
                in32_data  <= in_data[63:32];
                in32_nbits <= in_long ? 6'd32 : in_nbits[5:0];
                in32_tlast <= in_tlast & ~in_long;
            end
        end
    end

    // accumulator, valid bits left-aligned from bit 63
    assign out_tlast  = tlast_cycle & (bit_count <= 7'd32);
    assign out_valid  = out_tlast | (bit_count >= 7'd32);
    assign rounded    = bit_count + 7'd7;
    assign out_nbytes = out_tlast ? rounded[5:3] : 3'd4;
    assign out_data   = bit_packer[63:32]
                      | (out_tlast ? (32'hffff_ffff >> bit_count) : 32'h0);   // one padding

    // no new bits while a segment end is draining
    assign in32_hold = (out_valid & out_hold) | (tlast_cycle & ~out_tlast);
    assign in32_take = in32_valid & ~in32_hold;
    assign emit      = out_valid & ~out_hold;

    always_comb begin
        count_decr = '0;
        if (emit) begin
            count_decr = out_tlast ? bit_count : 7'd32;
        end
        count_incr = in32_take ? nbits64_t'(in32_nbits) : '0;
        load       = in32_take ? {32'h0, in32_data} : '0;
        remain     = bit_count - count_decr;
        next_bit_count = remain + count_incr;

        shifted = emit ? (bit_packer << 32) : bit_packer;
        next_bit_packer = shifted | (load << (7'd32 - remain));   // append after the kept bits

        next_tlast_cycle = (tlast_cycle & ~(out_tlast & emit)) | (in32_take & in32_tlast);
    end

    always_ff @(posedge clk) begin
        if (!resetn) begin
            bit_count   <= '0;
            bit_packer  <= '0;
            tlast_cycle <= 1'b0;
        end else begin
            bit_count   <= next_bit_count;
            bit_packer  <= next_bit_packer;
            tlast_cycle <= next_tlast_cycle;
        end
    end

    a_bit_count: assert property (@(posedge clk) disable iff (!resetn)
        bit_count <= 7'd63);

    // only the segment end may be short, and it is never empty
    a_nbytes: assert property (@(posedge clk) disable iff (!resetn)
        out_valid |-> (out_nbytes != '0) && (out_tlast || out_nbytes == 3'd4));

endmodule

`default_nettype wire

//--- hdl/byte_stuffer.sv
/* byte stuffer
   walks packed words out one byte per cycle, most significant first,
   and inserts a zero byte after every 0xff */
`timescale 1ns/10ps
`default_nettype none

module byte_stuffer
    import jpeg_tail_pkg::*;
(
    input  logic    clk,
    input  logic    resetn,

    input  word32_t pack_data,
    input  nbytes_t pack_nbytes,
    input  logic    pack_tlast,
    input  logic    pack_valid,
    output logic    pack_hold,

    output byte_t   out_byte,
    output logic    out_tlast,
    output logic    out_valid,
    input  logic    out_hold
);

    word32_t held_data;     // current byte always in the top lane
    nbytes_t held_nbytes;
    logic    held_tlast;
    logic    held_valid;
    nbytes_t idx;           // bytes already sent from the held word
    logic    stuff;         // zero byte goes out this cycle
    logic    cur_ff;
    logic    last_out;
    logic    step;
    logic    load;

    assign cur_ff   = held_data[31:24] == STUFF_BYTE;
    // final output of the word, the zero byte when the last byte is 0xff
    assign last_out = (nbytes_t'(idx + 3'd1) == held_nbytes) & (stuff | ~cur_ff);

    assign out_valid = held_valid;
    assign out_byte  = stuff ? 8'h00 : held_data[31:24];
    assign out_tlast = held_valid & held_tlast & last_out;

    assign step      = held_valid & ~out_hold;
    assign pack_hold = held_valid & ~(~out_hold & last_out);   // next word may load as we finish
    assign load      = pack_valid & ~pack_hold;

    always_ff @(posedge clk) begin
        if (!resetn) begin
            held_valid <= 1'b0;
            stuff      <= 1'b0;
            idx        <= '0;
        end else begin
            if (step) begin
                if (cur_ff & ~stuff) begin
                    stuff <= 1'b1;
                end else begin
                    stuff <= 1'b0;
                    idx   <= idx + 3'd1;
                    if (last_out) begin
                        held_valid <= 1'b0;
                    end
                end
            end
            if (load) begin
                held_valid <= 1'b1;
                stuff      <= 1'b0;
                idx        <= '0;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (load) begin
            held_data   <= pack_data;
            held_nbytes <= pack_nbytes;
            held_tlast  <= pack_tlast;
        end else if (step & ~(cur_ff & ~stuff)) begin
            held_data <= held_data << 8;   // next byte to the top
        end
    end

    // index stays inside the byte count taken from the packer
    a_idx: assert property (@(posedge clk) disable iff (!resetn)
        held_valid |-> idx < held_nbytes);

endmodule

`default_nettype wire

//--- hdl/jpeg_tail.sv
/* jpeg entropy coder tail
   huffman symbols in, stuffed scan bytes out */
`timescale 1ns/10ps
`default_nettype none

module jpeg_tail
    import jpeg_tail_pkg::*;
(
    input  logic      clk,
    input  logic      resetn,

    input  code_t     sym_code,
    input  code_len_t sym_code_len,
    input  amp_t      sym_amp,
    input  logic      sym_tlast,
    input  logic      sym_valid,
    output logic      sym_hold,

    output byte_t     out_byte,
    output logic      out_tlast,
    output logic      out_valid,
    input  logic      out_hold
);

    word64_t  pair_data;
    nbits64_t pair_nbits;
    logic     pair_tlast;
    logic     pair_valid;
    logic     pair_hold;

    word32_t  pack_data;
    nbytes_t  pack_nbytes;
    logic     pack_tlast;
    logic     pack_valid;
    logic     pack_hold;

    amp_merge u_amp_merge (
        .clk          (clk),
        .resetn       (resetn),
        .sym_code     (sym_code),
        .sym_code_len (sym_code_len),
        .sym_amp      (sym_amp),
        .sym_tlast    (sym_tlast),
        .sym_valid    (sym_valid),
        .sym_hold     (sym_hold),
        .pair_data    (pair_data),
        .pair_nbits   (pair_nbits),
        .pair_tlast   (pair_tlast),
        .pair_valid   (pair_valid),
        .pair_hold    (pair_hold)
    );

    bit_pack u_bit_pack (
        .in_data    (pair_data),
        .in_nbits   (pair_nbits),
        .in_tlast   (pair_tlast),
        .in_valid   (pair_valid),
        .in_hold    (pair_hold),
        .out_data   (pack_data),
        .out_nbytes (pack_nbytes),
        .out_tlast  (pack_tlast),
        .out_valid  (pack_valid),
        .out_hold   (pack_hold),
        .clk        (clk),
        .resetn     (resetn)
    );

    byte_stuffer u_byte_stuffer (
        .clk         (clk),
        .resetn      (resetn),
        .pack_data   (pack_data),
        .pack_nbytes (pack_nbytes),
        .pack_tlast  (pack_tlast),
        .pack_valid  (pack_valid),
        .pack_hold   (pack_hold),
        .out_byte    (out_byte),
        .out_tlast   (out_tlast),
        .out_valid   (out_valid),
        .out_hold    (out_hold)
    );

endmodule

`default_nettype wire

//--- dv/jpeg_tail_tb.sv
/* testbench for the jpeg entropy coder tail
   random huffman symbols in, scan bytes checked against a bit-level model */
`timescale 1ns/10ps
`default_nettype none

module jpeg_tail_tb
    import jpeg_tail_pkg::*;
();

    logic      clk = 1'b0;
    logic      resetn;
    code_t     sym_code;
    code_len_t sym_code_len;
    amp_t      sym_amp;
    logic      sym_tlast;
    logic      sym_valid;
    logic      sym_hold;
    byte_t     out_byte;
    logic      out_tlast;
    logic      out_valid;
    logic      out_hold = 1'b0;

    code_t     stim_code [$];
    code_len_t stim_len  [$];
    amp_t      stim_amp  [$];
    logic      stim_last [$];
    byte_t     exp_bytes [$];    // expected scan stream
    logic      exp_lasts [$];
    byte_t     part_byte;        // model bits not yet forming a whole byte
    int        part_bits;
    int        rd_idx = 0;
    int        cycles = 0;
    int        cycle_limit;
    int        hold_rnd;
    byte_t     last_byte;
    logic      started = 1'b0;
    integer    seed = 38;

    jpeg_tail dut (
        .clk          (clk),
        .resetn       (resetn),
        .sym_code     (sym_code),
        .sym_code_len (sym_code_len),
        .sym_amp      (sym_amp),
        .sym_tlast    (sym_tlast),
        .sym_valid    (sym_valid),
        .sym_hold     (sym_hold),
        .out_byte     (out_byte),
        .out_tlast    (out_tlast),
        .out_valid    (out_valid),
        .out_hold     (out_hold)
    );

    always #20 clk = ~clk;

    task automatic stop_on_error(input string why);
        $display("%s", why);
        $display("Test failures found");
        $fatal(1);
    endtask

    function automatic int rand_range(input int lo, input int hi);
        int r;
        r = $random(seed) & 32'h7fff_ffff;
        return lo + r % (hi - lo + 1);
    endfunction

    // jpeg size category is the bit length of the magnitude
    function automatic int size_of(input int amp);
        int mag;
        int size;
        mag  = (amp < 0) ? -amp : amp;
        size = 0;
        while (mag != 0) begin
            size++;
            mag = mag >> 1;
        end
        return size;
    endfunction

    function automatic int amp_of_size(input int size);
        int mag;
        if (size == 0) begin
            return 0;
        end
        mag = rand_range(1 << (size - 1), (1 << size) - 1);
        return (rand_range(0, 1) == 1) ? -mag : mag;
    endfunction

    task automatic put_byte(input byte_t b);
        exp_bytes.push_back(b);
        exp_lasts.push_back(1'b0);
        if (b == 8'hff) begin
            exp_bytes.push_back(8'h00);   // stuffed zero
            exp_lasts.push_back(1'b0);
        end
    endtask

    task automatic put_bits(input int value, input int len);
        for (int k = len - 1; k >= 0; k--) begin
            part_byte = {part_byte[6:0], value[k]};
            part_bits++;
            if (part_bits == 8) begin
                put_byte(part_byte);
                part_bits = 0;
            end
        end
    endtask

    task automatic add_symbol(input int code, input int len, input int amp, input logic last);
        int size;
        int bits;
        size = size_of(amp);
        bits = (amp < 0) ? amp + (1 << size) - 1 : amp;   // ones' complement for negatives
        stim_code.push_back(code_t'(code));
        stim_len.push_back(code_len_t'(len));
        stim_amp.push_back(amp_t'(amp));
        stim_last.push_back(last);
        put_bits(code, len);
        put_bits(bits, size);
        if (last) begin
            while (part_bits != 0) begin
                put_bits(1, 1);   // pad with ones
            end
            exp_lasts[exp_lasts.size() - 1] = 1'b1;
        end
    endtask

    task automatic add_random_code(input int amp, input logic last);
        int len;
        len = rand_range(1, MAX_CODE_LEN);
        add_symbol(rand_range(0, (1 << len) - 1), len, amp, last);
    endtask

    task automatic build_tests();
        int mag;
        int len;
        // one-symbol segments with both signs of every size category
        for (int s = 0; s <= MAX_AMP_SIZE; s++) begin
            mag = (s == 0) ? 0 : rand_range(1 << (s - 1), (1 << s) - 1);
            add_random_code(mag, 1'b1);
            add_random_code(-mag, 1'b1);
        end
        // 16-bit codes with size-11 amplitudes give 54-bit pairs
        for (int seg = 0; seg < 2; seg++) begin
            for (int k = 0; k < 40 + seg; k++) begin
                add_symbol(rand_range(0, 16'hffff), MAX_CODE_LEN,
                           amp_of_size(MAX_AMP_SIZE), k == 39 + seg);
            end
        end
        // last code length picks the segment length mod 8
        for (int r = 0; r < 8; r++) begin
            add_random_code(amp_of_size(rand_range(0, MAX_AMP_SIZE)), 1'b0);
            add_random_code(amp_of_size(rand_range(0, MAX_AMP_SIZE)), 1'b0);
            len = 8 + ((r - part_bits + 8) % 8);
            add_symbol(rand_range(0, (1 << len) - 1), len, 0, 1'b1);
        end
        for (int seg = 0; seg < 4; seg++) begin
            for (int k = 0; k < 6; k++) begin
                len = rand_range(1, MAX_CODE_LEN);
                mag = rand_range(1, MAX_AMP_SIZE);
                add_symbol((1 << len) - 1, len, (1 << mag) - 1, k == 5);   // runs of ones
            end
        end
        add_symbol(16'hffff, MAX_CODE_LEN, 2047, 1'b1);
        for (int seg = 0; seg < 6; seg++) begin
            len = rand_range(1, 12);
            for (int k = 0; k < len; k++) begin
                add_random_code(amp_of_size(rand_range(0, MAX_AMP_SIZE)), k == len - 1);
            end
        end
    endtask

    // drives one symbol per beat and moves on only when it was taken
    task automatic send_symbols();
        int i;
        logic taken;
        i = 0;
        while (i < stim_code.size()) begin
            sym_code     = stim_code[i];
            sym_code_len = stim_len[i];
            sym_amp      = stim_amp[i];
            sym_tlast    = stim_last[i];
            sym_valid    = 1'b1;
            started      = 1'b1;
            @(negedge clk);
            taken = ~sym_hold;
            @(posedge clk);
            #1;
            if (taken) begin
                i++;
            end
        end
        sym_valid = 1'b0;
        sym_tlast = 1'b0;
    endtask

    always begin
        @(posedge clk);
        #1;
        hold_rnd = $random(seed);
        out_hold = resetn & hold_rnd[0];   // back-pressure half of the time
    end

    always @(posedge clk) begin
        last_byte <= out_byte;
        if (resetn && out_valid && !out_hold) begin
            rd_idx <= rd_idx + 1;
        end
    end

    always @(posedge clk) begin
        cycles <= cycles + 1;
        if (cycles >= cycle_limit) begin
            stop_on_error($sformatf("timeout after %0d cycles with %0d of %0d bytes received",
                                    cycles, rd_idx, exp_bytes.size()));
        end
    end

    a_idle: assert property (@(posedge clk) disable iff (!resetn)
        !started |-> (!out_valid && !out_tlast && !sym_hold))
        else stop_on_error("output active or sym_hold high before any symbol was sent");

    a_byte: assert property (@(posedge clk) disable iff (!resetn)
        (out_valid && !out_hold && rd_idx < exp_bytes.size()) |-> out_byte == exp_bytes[rd_idx])
        else stop_on_error($sformatf("MISMATCH time=%0t out_byte expected=%02h actual=%02h",
                                     $time, exp_bytes[$sampled(rd_idx)], $sampled(out_byte)));

    a_tlast: assert property (@(posedge clk) disable iff (!resetn)
        (out_valid && !out_hold && rd_idx < exp_bytes.size()) |-> out_tlast == exp_lasts[rd_idx])
        else stop_on_error($sformatf("MISMATCH time=%0t out_tlast expected=%0b actual=%0b",
                                     $time, exp_lasts[$sampled(rd_idx)], $sampled(out_tlast)));

    a_extra: assert property (@(posedge clk) disable iff (!resetn)
        out_valid |-> rd_idx < exp_bytes.size())
        else stop_on_error("DUT sent more bytes than the model expects");

    // a held byte stays on the port
    a_stable: assert property (@(posedge clk) disable iff (!resetn)
        (out_valid && out_hold) |=> (out_valid && out_byte == last_byte))
        else stop_on_error($sformatf("MISMATCH time=%0t out_byte expected=%02h actual=%02h",
                                     $time, $sampled(last_byte), $sampled(out_byte)));

    initial begin
        resetn       = 1'b0;
        sym_code     = '0;
        sym_code_len = '0;
        sym_amp      = '0;
        sym_tlast    = 1'b0;
        sym_valid    = 1'b0;
        part_byte    = '0;
        part_bits    = 0;
        build_tests();
        cycle_limit = 20 * stim_code.size() + 200;
        repeat (5) @(posedge clk);
        #1;
        resetn = 1'b1;
        repeat (4) @(posedge clk);   // outputs stay quiet while idle
        #1;
        send_symbols();
        while (rd_idx < exp_bytes.size()) begin
            @(posedge clk);
        end
        repeat (20) @(posedge clk);
        #1;
        if (rd_idx == exp_bytes.size() && !out_valid) begin
            $display("All tests passed!");
            $finish;
        end else begin
            stop_on_error($sformatf("byte count wrong at end of run, %0d sent for %0d expected",
                                    rd_idx, exp_bytes.size()));
        end
    end

endmodule

`default_nettype wire

//--- jpeg_tail.f
hdl/jpeg_tail_pkg.sv
hdl/amp_merge.sv
hdl/bit_pack.sv
hdl/byte_stuffer.sv
hdl/jpeg_tail.sv
dv/jpeg_tail_tb.sv

//--- run.sh
#!/bin/sh
# build the jpeg_tail testbench with verilator and run it
# the exit status is nonzero when the build or the simulation fails
cd "$(dirname "$0")" || exit 1
verilator --binary --timing --assert --top-module jpeg_tail_tb -f jpeg_tail.f \
    && ./obj_dir/Vjpeg_tail_tb \
    || { echo "simulation run failed"; exit 1; }
